// ==== build.f ====
+incdir+hdl
hdl/ecc_pkg.sv
hdl/ecc_check_bits.sv
hdl/ecc_syndrome_decoder.sv
hdl/ecc_codec_core.sv
hdl/ecc_pipe_stage.sv
hdl/ecc_114_top.sv
testbench/ecc_assertions.sv
testbench/ecc_tb.sv

// ==== Bender.yml ====
package:
  name: ecc_114

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/ecc_pkg.sv
      - hdl/ecc_check_bits.sv
      - hdl/ecc_syndrome_decoder.sv
      - hdl/ecc_codec_core.sv
      - hdl/ecc_pipe_stage.sv
      - hdl/ecc_114_top.sv

  - target: test
    include_dirs:
      - hdl
    files:
      - testbench/ecc_assertions.sv
      - testbench/ecc_tb.sv

// ==== testbench/ecc_tb.sv ====
`default_nettype none

`include "ecc_macros.svh"

module ecc_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [31:0] SEED    = 32'd5036;
    localparam int          TIMEOUT = 200;   // cycles per wait
    localparam int          WORDS   = 40;

    localparam int K_CLEAN  = 0;
    localparam int K_DATA   = 1;
    localparam int K_CHECK  = 2;
    localparam int K_DOUBLE = 3;
    localparam int K_BYPASS = 4;
    localparam int K_MIXED  = 5;

    logic             clk;
    logic             arst_n;
    logic             in_valid;
    logic             in_ready;
    ecc_pkg::data_t   data_in;
    ecc_pkg::parity_t parity_in;
    logic             bypass;
    logic             out_valid;
    logic             out_ready;
    ecc_pkg::data_t   data_out;
    ecc_pkg::parity_t parity_out;
    logic             sbit_err;
    logic             dbit_err;

    int unsigned                position[`ECC_DATA_W];
    logic [`ECC_DATA_W-1:0]     exp_data[$];
    logic [`ECC_PARITY_W-1:0]   exp_parity[$];
    logic                       exp_sbit[$];
    logic                       exp_dbit[$];
    logic [31:0]                stim_rng;
    logic [31:0]                sink_rng;
    string                      test_name;
    int                         error_count = 0;
    int                         check_count = 0;
    int                         tests_run = 0;
    int                         tests_failed = 0;
    bit                         aborted = 0;
    bit                         saw_in_ready_low;

    ecc_114_top UUT (
        .clk        (clk),
        .arst_n     (arst_n),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .data_in    (data_in),
        .parity_in  (parity_in),
        .bypass     (bypass),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .data_out   (data_out),
        .parity_out (parity_out),
        .sbit_err   (sbit_err),
        .dbit_err   (dbit_err)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_stim();
        stim_rng = xorshift32(stim_rng);
        return stim_rng;
    endfunction

    function automatic logic [`ECC_DATA_W-1:0] random_data();
        logic [127:0] wide;
        wide = {next_stim(), next_stim(), next_stim(), next_stim()};
        return wide[`ECC_DATA_W-1:0];
    endfunction

    // walk positions from 3 and skip the powers of two
    task automatic build_positions();
        int unsigned count;
        int unsigned pos;
        count = 0;
        for (pos = 3; count < `ECC_DATA_W; pos++) begin
            if ((pos & (pos - 1)) != 0) begin
                position[count] = pos;
                count++;
            end
        end
    endtask

    function automatic logic [`ECC_PARITY_W-1:0] model_check(input logic [`ECC_DATA_W-1:0] d);
        logic [`ECC_PARITY_W-1:0]  chk;
        logic [`ECC_HAMMING_W-1:0] pos;
        chk = '0;
        for (int i = 0; i < `ECC_DATA_W; i++) begin
            pos = position[i][`ECC_HAMMING_W-1:0];
            if (d[i]) begin
                chk[`ECC_HAMMING_W-1:0] = chk[`ECC_HAMMING_W-1:0] ^ pos;
                if ($countones(pos) % 2 == 0) begin
                    chk[`ECC_PARITY_W-1] = ~chk[`ECC_PARITY_W-1];   // balancing bit
                end
            end
        end
        return chk;
    endfunction

    task automatic predict(input logic [`ECC_DATA_W-1:0] d, input logic [`ECC_PARITY_W-1:0] p,
                           input logic bp, output logic [`ECC_DATA_W-1:0] od,
                           output logic [`ECC_PARITY_W-1:0] op, output logic osb,
                           output logic odb);
        logic [`ECC_PARITY_W-1:0]  syn;
        logic [`ECC_HAMMING_W-1:0] pos;
        bit                        hit;
        op  = model_check(d);
        syn = p ^ op;
        od  = d;
        osb = 1'b0;
        odb = 1'b0;
        hit = 0;
        if (!bp && syn != '0) begin
            for (int i = 0; i < `ECC_DATA_W; i++) begin
                pos = position[i][`ECC_HAMMING_W-1:0];
                if (syn[`ECC_HAMMING_W-1:0] == pos
                        && syn[`ECC_PARITY_W-1] == ($countones(pos) % 2 == 0)) begin
                    od[i] = ~od[i];
                    hit   = 1;
                end
            end
            if (hit || $countones(syn) == 1) begin
                osb = 1'b1;
            end else begin
                odb = 1'b1;
            end
        end
    endtask

    task automatic compare(input string what, input logic [127:0] expected,
                           input logic [127:0] actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("FAILED %s: %s expected %0h actual %0h", test_name, what, expected, actual);
        end
    endtask

    task automatic send_words(input int kind, input int count);
        logic [`ECC_DATA_W-1:0]   d;
        logic [`ECC_PARITY_W-1:0] p;
        logic [`ECC_DATA_W-1:0]   ed;
        logic [`ECC_PARITY_W-1:0] ep;
        logic                     bp;
        logic                     es;
        logic                     eb;
        int                       k;
        int                       a;
        int                       b;
        int                       waited;
        for (int n = 0; n < count && !aborted; n++) begin
            k  = (kind == K_MIXED) ? int'(next_stim() % 5) : kind;
            d  = random_data();
            p  = model_check(d);   // check bits of the clean word
            bp = 1'b0;
            a  = next_stim() % `ECC_DATA_W;
            b  = (a + 1 + int'(next_stim() % (`ECC_DATA_W - 1))) % `ECC_DATA_W;
            if (k == K_BYPASS) begin
                bp = 1'b1;
                k  = next_stim() % 4;   // clean, data, check or double corruption
            end
            case (k)
                K_DATA: d[a] = ~d[a];
                K_CHECK: p[a % `ECC_PARITY_W] = ~p[a % `ECC_PARITY_W];
                K_DOUBLE: begin
                    d[a] = ~d[a];
                    d[b] = ~d[b];
                end
                default: ;
            endcase
            @(negedge clk);
            in_valid  = 1'b1;
            data_in   = d;
            parity_in = p;
            bypass    = bp;
            #1;
            waited = 0;
            while (!in_ready && waited < TIMEOUT) begin
                saw_in_ready_low = 1;
                waited++;
                @(negedge clk);
                #1;
            end
            if (!in_ready) begin
                $display("ERROR: %s, in_ready stayed low for %0d cycles", test_name, TIMEOUT);
                error_count++;
                aborted = 1;
            end else begin
                // accepted on the coming rising edge
                predict(d, p, bp, ed, ep, es, eb);
                exp_data.push_back(ed);
                exp_parity.push_back(ep);
                exp_sbit.push_back(es);
                exp_dbit.push_back(eb);
            end
        end
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    task automatic receive_words(input int count, input bit stall);
        int got;
        int idle;
        got  = 0;
        idle = 0;
        while (got < count && idle < TIMEOUT) begin
            @(negedge clk);
            if (stall) begin
                sink_rng  = xorshift32(sink_rng);
                out_ready = sink_rng[0];
            end else begin
                out_ready = 1'b1;
            end
            #1;
            if (out_valid && out_ready) begin
                if (exp_data.size() == 0) begin
                    $display("ERROR: %s, a word came out that was never sent", test_name);
                    error_count++;
                end else begin
                    compare("data_out", exp_data.pop_front(), data_out);
                    compare("parity_out", exp_parity.pop_front(), parity_out);
                    compare("sbit_err", exp_sbit.pop_front(), sbit_err);
                    compare("dbit_err", exp_dbit.pop_front(), dbit_err);
                end
                got++;
                idle = 0;
            end else begin
                idle++;
            end
        end
        if (got < count) begin
            $display("ERROR: %s, no output word for %0d cycles", test_name, TIMEOUT);
            error_count++;
            aborted = 1;
        end
    endtask

    task automatic run_test(input string name, input int kind, input bit stall);
        int errors_before;
        errors_before    = error_count;
        test_name        = name;
        saw_in_ready_low = 0;
        fork
            send_words(kind, WORDS);
            receive_words(WORDS, stall);
        join
        if (stall) begin
            compare("in_ready low seen", 1, saw_in_ready_low);
        end
        if (exp_data.size() != 0) begin
            $display("ERROR: %s, %0d accepted words never came out", name, exp_data.size());
            error_count++;
            exp_data.delete();
            exp_parity.delete();
            exp_sbit.delete();
            exp_dbit.delete();
        end
        tests_run++;
        if (error_count != errors_before) begin
            tests_failed++;
        end
        $display("test %s done, %0d words, %0d errors", name, WORDS,
                 error_count - errors_before);
    endtask

    initial begin
        clk       = 1'b0;
        arst_n    = 1'b0;
        in_valid  = 1'b0;
        data_in   = '0;
        parity_in = '0;
        bypass    = 1'b0;
        out_ready = 1'b0;
        stim_rng  = SEED;
        sink_rng  = xorshift32(SEED);   // separate stream for the sink
        build_positions();
        repeat (5) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        #1;
        test_name = "reset";
        compare("in_ready", 1, in_ready);
        compare("out_valid", 0, out_valid);
        tests_run++;
        if (error_count != 0) begin
            tests_failed++;
        end
        $display("test reset done, %0d errors", error_count);
        run_test("clean_words", K_CLEAN, 0);
        if (!aborted) run_test("data_bit_error", K_DATA, 0);
        if (!aborted) run_test("check_bit_error", K_CHECK, 0);
        if (!aborted) run_test("double_error", K_DOUBLE, 0);
        if (!aborted) run_test("bypass", K_BYPASS, 0);
        if (!aborted) run_test("backpressure", K_MIXED, 1);
        $display("%0d tests, %0d failed, %0d checks, %0d errors, %0d assertion failures",
                 tests_run, tests_failed, check_count, error_count,
                 UUT.u_assertions.fail_count);
        if (error_count == 0 && UUT.u_assertions.fail_count == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== testbench/ecc_assertions.sv ====
`default_nettype none

module ecc_assertions (
    input logic             clk,
    input logic             arst_n,
    input logic             out_valid,
    input logic             out_ready,
    input ecc_pkg::data_t   data_out,
    input ecc_pkg::parity_t parity_out,
    input logic             sbit_err,
    input logic             dbit_err
);

    timeunit 1ns;
    timeprecision 1ps;

    int unsigned fail_count = 0;

    // a stalled output word must not move
    held_while_stalled: assert property (@(posedge clk) disable iff (!arst_n)
        out_valid && !out_ready |=> out_valid && $stable(data_out) && $stable(parity_out)
            && $stable(sbit_err) && $stable(dbit_err))
    else begin
        $error("output word changed while out_ready was low");
        fail_count++;
    end

    flags_exclusive: assert property (@(posedge clk) disable iff (!arst_n)
        out_valid |-> !(sbit_err && dbit_err))
    else begin
        $error("sbit_err and dbit_err high together");
        fail_count++;
    end

    idle_in_reset: assert property (@(posedge clk) !arst_n |-> !out_valid)
    else begin
        $error("out_valid high during reset");
        fail_count++;
    end

endmodule

bind ecc_114_top ecc_assertions u_assertions (
    .clk        (clk),
    .arst_n     (arst_n),
    .out_valid  (out_valid),
    .out_ready  (out_ready),
    .data_out   (data_out),
    .parity_out (parity_out),
    .sbit_err   (sbit_err),
    .dbit_err   (dbit_err)
);

`default_nettype wire

// ==== hdl/ecc_114_top.sv ====
`default_nettype none

module ecc_114_top (
    input  logic             clk,
    input  logic             arst_n,
    input  logic             in_valid,
    output logic             in_ready,
    input  ecc_pkg::data_t   data_in,
    input  ecc_pkg::parity_t parity_in,
    input  logic             bypass,
    output logic             out_valid,
    input  logic             out_ready,
    output ecc_pkg::data_t   data_out,
    output ecc_pkg::parity_t parity_out,
    output logic             sbit_err,
    output logic             dbit_err
);

    ecc_pkg::in_payload_t  in_d;
    ecc_pkg::in_payload_t  in_q;
    ecc_pkg::out_payload_t out_d;
    ecc_pkg::out_payload_t out_q;
    logic                  mid_valid;
    logic                  mid_ready;

    assign in_d.data   = data_in;
    assign in_d.parity = parity_in;
    assign in_d.bypass = bypass;

    // stage 1, received word
    ecc_pipe_stage #(
        .payload_t (ecc_pkg::in_payload_t)
    ) u_in_stage (
        .clk         (clk),
        .arst_n      (arst_n),
        .in_valid    (in_valid),
        .in_ready    (in_ready),
        .in_payload  (in_d),
        .out_valid   (mid_valid),
        .out_ready   (mid_ready),
        .out_payload (in_q)
    );

    ecc_codec_core u_core (
        .data_in    (in_q.data),
        .parity_in  (in_q.parity),
        .bypass     (in_q.bypass),
        .data_out   (out_d.data),
        .parity_out (out_d.parity),
        .sbit_err   (out_d.sbit_err),
        .dbit_err   (out_d.dbit_err)
    );

    // stage 2, decoded word
    ecc_pipe_stage #(
        .payload_t (ecc_pkg::out_payload_t)
    ) u_out_stage (
        .clk         (clk),
        .arst_n      (arst_n),
        .in_valid    (mid_valid),
        .in_ready    (mid_ready),
        .in_payload  (out_d),
        .out_valid   (out_valid),
        .out_ready   (out_ready),
        .out_payload (out_q)
    );

    assign data_out   = out_q.data;
    assign parity_out = out_q.parity;
    assign sbit_err   = out_q.sbit_err;
    assign dbit_err   = out_q.dbit_err;

endmodule

`default_nettype wire

// ==== hdl/ecc_pipe_stage.sv ====
`default_nettype none

module ecc_pipe_stage #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     arst_n,
    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_payload,
    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_payload
);

    logic     full;
    payload_t payload_q;

    // empty, or draining this cycle
    assign in_ready = ~full | out_ready;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            full <= 1'b0;
        end else if (in_ready) begin
            full <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            payload_q <= in_payload;
        end
    end

    assign out_valid   = full;
    assign out_payload = payload_q;

endmodule

`default_nettype wire

// ==== hdl/ecc_codec_core.sv ====
`default_nettype none

module ecc_codec_core (
    input  ecc_pkg::data_t   data_in,
    input  ecc_pkg::parity_t parity_in,
    input  logic             bypass,
    output ecc_pkg::data_t   data_out,
    output ecc_pkg::parity_t parity_out,
    output logic             sbit_err,
    output logic             dbit_err
);

    ecc_pkg::parity_t syndrome;
    ecc_pkg::data_t   mask;
    logic             single_err;
    logic             double_err;

    ecc_check_bits u_check_bits (
        .data  (data_in),
        .check (parity_out)
    );

    assign syndrome = parity_in ^ parity_out;

    ecc_syndrome_decoder u_syndrome_decoder (
        .syndrome   (syndrome),
        .mask       (mask),
        .single_err (single_err),
        .double_err (double_err)
    );

    // bypass passes the word untouched
    always_comb begin
        if (bypass) begin
            data_out = data_in;
            sbit_err = 1'b0;
            dbit_err = 1'b0;
        end else begin
            data_out = data_in ^ mask;   // flips at most one bit
            sbit_err = single_err;
            dbit_err = double_err;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/ecc_syndrome_decoder.sv ====
`default_nettype none

`include "ecc_macros.svh"

module ecc_syndrome_decoder (
    input  ecc_pkg::parity_t syndrome,
    output ecc_pkg::data_t   mask,
    output logic             single_err,
    output logic             double_err
);

    logic col_hit;
    logic check_hit;
    logic nonzero;

    // one-hot on the data column that matches the syndrome
    always_comb begin
        logic [`ECC_HAMMING_W-1:0] pos;
        ecc_pkg::parity_t          column;
        mask = '0;
        for (int i = 0; i < `ECC_DATA_W; i++) begin
            pos    = ecc_pkg::data_position(i);
            column = {~^pos, pos};
            if (syndrome == column) begin
                mask[i] = 1'b1;
            end
        end
    end

    assign col_hit = |mask;
    assign nonzero = |syndrome;

    // a lone syndrome bit points at a check bit, data stays as is
    assign check_hit = nonzero && ((syndrome & (syndrome - 1'b1)) == '0);

    assign single_err = col_hit | check_hit;
    assign double_err = nonzero & ~single_err;   // even weight or unused column

endmodule

`default_nettype wire

// ==== hdl/ecc_check_bits.sv ====
`default_nettype none

`include "ecc_macros.svh"

module ecc_check_bits (
    input  ecc_pkg::data_t   data,
    output ecc_pkg::parity_t check
);

    logic [`ECC_HAMMING_W-1:0] hamming;
    logic                      balance;

    // sum over the data bits that cover each position bit
    always_comb begin
        logic [`ECC_HAMMING_W-1:0] pos;
        hamming = '0;
        for (int i = 0; i < `ECC_DATA_W; i++) begin
            pos = ecc_pkg::data_position(i);
            for (int j = 0; j < `ECC_HAMMING_W; j++) begin
                if (pos[j]) begin
                    hamming[j] = hamming[j] ^ data[i];
                end
            end
        end
    end

    // extra bit makes every data column odd weight
    always_comb begin
        logic [`ECC_HAMMING_W-1:0] pos;
        balance = 1'b0;
        for (int i = 0; i < `ECC_DATA_W; i++) begin
            pos = ecc_pkg::data_position(i);
            if (~^pos) begin   // even number of ones
                balance = balance ^ data[i];
            end
        end
    end

    assign check = {balance, hamming};

endmodule

`default_nettype wire

// ==== hdl/ecc_pkg.sv ====
`default_nettype none

`include "ecc_macros.svh"

package ecc_pkg;

    typedef logic [`ECC_DATA_W-1:0]   data_t;
    typedef logic [`ECC_PARITY_W-1:0] parity_t;

    // received word
    typedef struct packed {
        data_t   data;
        parity_t parity;
        logic    bypass;
    } in_payload_t;

    // decoded word
    typedef struct packed {
        data_t   data;
        parity_t parity;   // computed check bits
        logic    sbit_err;
        logic    dbit_err;
    } out_payload_t;

    // hamming position of data bit i, powers of two are skipped
    function automatic logic [`ECC_HAMMING_W-1:0] data_position(input int unsigned i);
        int unsigned pos;
        pos = i + 3;   // positions 1 and 2 hold check bits
        for (int k = 2; k < `ECC_HAMMING_W; k++) begin
            if (pos >= (1 << k)) begin
                pos++;
            end
        end
        return pos[`ECC_HAMMING_W-1:0];
    endfunction

endpackage

`default_nettype wire

// ==== hdl/ecc_macros.svh ====
`ifndef ECC_MACROS_SVH
`define ECC_MACROS_SVH

// data word width of the codec
`define ECC_DATA_W 114

// check bits per word, hamming bits plus one balancing bit
`define ECC_PARITY_W 8

// position based check bits
`define ECC_HAMMING_W 7

`endif
